// ==== verilog/erx_pkg.sv ====
package erx_pkg;

   // ########################################################################
   // Emesh packet format
   // ########################################################################

   // Packet layout, low bit first
   //   [0]       write flag
   //   [2:1]     datamode
   //   [7:3]     ctrlmode
   //   [39:8]    destination address
   //   [71:40]   data
   //   [103:72]  source address

   // Full packet width
   localparam int pw = 104;

   // Address width of both address fields
   localparam int aw = 32;

   // Write flag, set for writes, clear for read requests
   localparam int write_bit = 0;

   // Lowest bit of the destination address
   localparam int dstaddr_lsb = 8;

   // ########################################################################
   // Link identity
   // ########################################################################

   // Top bit of the ID slice, counted within the address
   localparam int id_msb = 31;

   // This link's ID
   // Matched against dstaddr[31:20]
   // Anything carrying it is a response coming back to us
   localparam logic [11:0] link_id = 12'h800;

   // ########################################################################
   // Receive queues
   // ########################################################################

   // Pointer width of each queue FIFO
   localparam int fifo_aw = 3;

   // Entries per queue
   // Kept a power of two so the pointers wrap on their own
   localparam int fifo_depth = 1 << fifo_aw;

   // Queue summary
   //   rxwr  master write queue, link writes not for us
   //   rxrd  master read queue, link reads not for us plus DMA reads
   //   rxrr  read response queue, link traffic for us plus register readback

endpackage

// ==== verilog/erx_ingress.sv ====
module erx_ingress (
   input  logic                   clk,
   input  logic                   reset,

   // Link side, after address translation
   input  logic                   erx_access,
   input  logic [erx_pkg::pw-1:0] erx_packet,
   output logic                   erx_wait,

   // Toward the arbiter
   input  logic                   stall,
   output logic                   held_access,
   output logic [erx_pkg::pw-1:0] held_packet
);

   // ########################################################################
   // Handshake toward the link
   // ########################################################################

   logic load;

   // Blocked only with something held that cannot move on
   // Empty slot or a departing packet frees it the same cycle
   assign erx_wait = held_access & stall;

   // New packet taken on this edge
   assign load = erx_access & ~erx_wait;

   // ########################################################################
   // Holding register
   // ########################################################################

   // Occupancy flag
   always_ff @(posedge clk) begin
      if (reset) begin
         held_access <= 1'b0;
      end
      else if (!erx_wait) begin
         // Either empty or leaving now
         // Refill from the link, or go empty
         held_access <= erx_access;
      end
   end

   // Payload, only written when a packet is taken
   always_ff @(posedge clk) begin
      if (load) begin
         held_packet <= erx_packet;
      end
   end

   // Back-to-back flow
   //   edge N   packet A loaded
   //   edge N+1 A leaves to its queue, B loaded
   // One packet per cycle as long as stall stays low

endmodule

// ==== verilog/erx_arbiter.sv ====
module erx_arbiter (
   // Held link packet from the ingress register
   input  logic                   held_access,
   input  logic [erx_pkg::pw-1:0] held_packet,
   output logic                   stall,

   // Read requests from the DMA engine
   input  logic                   edma_access,
   input  logic [erx_pkg::pw-1:0] edma_packet,
   output logic                   edma_wait,

   // Register readback from the configuration block
   input  logic                   ecfg_access,
   input  logic [erx_pkg::pw-1:0] ecfg_packet,
   output logic                   ecfg_wait,

   // Master write queue
   input  logic                   rxwr_full,
   output logic                   rxwr_access,
   output logic [erx_pkg::pw-1:0] rxwr_packet,

   // Master read queue
   input  logic                   rxrd_full,
   output logic                   rxrd_access,
   output logic [erx_pkg::pw-1:0] rxrd_packet,

   // Read response queue
   input  logic                   rxrr_full,
   output logic                   rxrr_access,
   output logic [erx_pkg::pw-1:0] rxrr_packet
);

   // ########################################################################
   // Link packet decode
   // ########################################################################

   logic                   link_write;
   logic [erx_pkg::aw-1:0] link_dstaddr;
   logic                   id_hit;
   logic                   link_wr;
   logic                   link_rd;
   logic                   link_rr;

   assign link_write   = held_packet[erx_pkg::write_bit];
   assign link_dstaddr = held_packet[erx_pkg::dstaddr_lsb +: erx_pkg::aw];

   // Top 12 address bits against our own ID
   assign id_hit = link_dstaddr[erx_pkg::id_msb -: $bits(erx_pkg::link_id)]
                   == erx_pkg::link_id;

   // Exactly one of these when a packet is held
   // ID match wins over the read/write split
   assign link_rr = held_access & id_hit;
   assign link_wr = held_access & link_write & ~id_hit;
   assign link_rd = held_access & ~link_write & ~id_hit;

   // ########################################################################
   // Write path
   // ########################################################################

   // Link is the only writer
   assign rxwr_access = link_wr & ~rxwr_full;
   assign rxwr_packet = held_packet;

   // ########################################################################
   // Read request path
   // ########################################################################

   // Link read ahead of DMA
   assign rxrd_access = (link_rd | edma_access) & ~rxrd_full;
   assign rxrd_packet = link_rd ? held_packet : edma_packet;

   // ########################################################################
   // Read response path
   // ########################################################################

   // Register readback ahead of link traffic
   assign rxrr_access = (ecfg_access | link_rr) & ~rxrr_full;
   assign rxrr_packet = ecfg_access ? ecfg_packet : held_packet;

   // ########################################################################
   // Wait generation
   // ########################################################################

   // Link held back by its own target queue
   // or by readback owning the response queue
   assign stall = (link_wr & rxwr_full) |
                  (link_rd & rxrd_full) |
                  (link_rr & (rxrr_full | ecfg_access));

   // DMA loses the read queue to a link read
   assign edma_wait = rxrd_full | link_rd;

   // Readback never loses arbitration, only space
   assign ecfg_wait = rxrr_full;

endmodule

// ==== verilog/erx_fifo.sv ====
module erx_fifo #(
   parameter int depth = erx_pkg::fifo_depth
) (
   input  logic                   clk,
   input  logic                   reset,

   // Producer side, already qualified by ~full
   input  logic                   push,
   input  logic [erx_pkg::pw-1:0] push_packet,
   output logic                   full,

   // Consumer side
   input  logic                   pop,
   output logic                   valid,
   output logic [erx_pkg::pw-1:0] head_packet
);

   // ########################################################################
   // Storage and pointers
   // ########################################################################

   // Pointers wrap naturally for power-of-two depth
   localparam int ptr_w = $clog2(depth);
   // One extra bit so a full count fits
   localparam int cnt_w = $clog2(depth + 1);

   logic [erx_pkg::pw-1:0] mem [depth];
   logic [ptr_w-1:0]       wr_ptr;
   logic [ptr_w-1:0]       rd_ptr;
   logic [cnt_w-1:0]       count;
   logic                   pop_en;

   // Pop on an empty queue does nothing
   assign pop_en = pop & valid;

   // ########################################################################
   // Control
   // ########################################################################

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         if (push && !pop_en) begin
            count <= count + 1'b1;
         end
         else if (pop_en && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   // Entry written at the write pointer
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_packet;
      end
   end

   // ########################################################################
   // Flags and head
   // ########################################################################

   assign full        = count == cnt_w'(depth);
   assign valid       = count != '0;

   // Head shows straight from the array
   assign head_packet = mem[rd_ptr];

endmodule

// ==== verilog/erx_core.sv ====
module erx_core (
   input  logic                   clk,
   input  logic                   reset,

   // Link side, translated packets
   input  logic                   erx_access,
   input  logic [erx_pkg::pw-1:0] erx_packet,
   output logic                   erx_wait,

   // DMA read requests
   input  logic                   edma_access,
   input  logic [erx_pkg::pw-1:0] edma_packet,
   output logic                   edma_wait,

   // Configuration readback
   input  logic                   ecfg_access,
   input  logic [erx_pkg::pw-1:0] ecfg_packet,
   output logic                   ecfg_wait,

   // Master write queue
   input  logic                   rxwr_rd,
   output logic                   rxwr_valid,
   output logic [erx_pkg::pw-1:0] rxwr_packet,

   // Master read queue
   input  logic                   rxrd_rd,
   output logic                   rxrd_valid,
   output logic [erx_pkg::pw-1:0] rxrd_packet,

   // Read response queue
   input  logic                   rxrr_rd,
   output logic                   rxrr_valid,
   output logic [erx_pkg::pw-1:0] rxrr_packet
);

   // ########################################################################
   // Internal nets
   // ########################################################################

   logic                   stall;
   logic                   held_access;
   logic [erx_pkg::pw-1:0] held_packet;

   // Arbiter to queue
   logic                   wr_push;
   logic [erx_pkg::pw-1:0] wr_push_packet;
   logic                   wr_full;
   logic                   rd_push;
   logic [erx_pkg::pw-1:0] rd_push_packet;
   logic                   rd_full;
   logic                   rr_push;
   logic [erx_pkg::pw-1:0] rr_push_packet;
   logic                   rr_full;

   // ########################################################################
   // Ingress register and routing
   // ########################################################################

   // Link packet registered once before routing
   erx_ingress ingress (
      .clk         (clk),
      .reset       (reset),
      .erx_access  (erx_access),
      .erx_packet  (erx_packet),
      .erx_wait    (erx_wait),
      .stall       (stall),
      .held_access (held_access),
      .held_packet (held_packet)
   );

   erx_arbiter arbiter (
      .held_access (held_access),
      .held_packet (held_packet),
      .stall       (stall),
      .edma_access (edma_access),
      .edma_packet (edma_packet),
      .edma_wait   (edma_wait),
      .ecfg_access (ecfg_access),
      .ecfg_packet (ecfg_packet),
      .ecfg_wait   (ecfg_wait),
      .rxwr_full   (wr_full),
      .rxwr_access (wr_push),
      .rxwr_packet (wr_push_packet),
      .rxrd_full   (rd_full),
      .rxrd_access (rd_push),
      .rxrd_packet (rd_push_packet),
      .rxrr_full   (rr_full),
      .rxrr_access (rr_push),
      .rxrr_packet (rr_push_packet)
   );

   // ########################################################################
   // Queues
   // ########################################################################

   // Same depth on all three
   erx_fifo #(.depth(erx_pkg::fifo_depth)) wr_fifo (
      .clk         (clk),
      .reset       (reset),
      .push        (wr_push),
      .push_packet (wr_push_packet),
      .full        (wr_full),
      .pop         (rxwr_rd),
      .valid       (rxwr_valid),
      .head_packet (rxwr_packet)
   );

   erx_fifo #(.depth(erx_pkg::fifo_depth)) rd_fifo (
      .clk         (clk),
      .reset       (reset),
      .push        (rd_push),
      .push_packet (rd_push_packet),
      .full        (rd_full),
      .pop         (rxrd_rd),
      .valid       (rxrd_valid),
      .head_packet (rxrd_packet)
   );

   erx_fifo #(.depth(erx_pkg::fifo_depth)) rr_fifo (
      .clk         (clk),
      .reset       (reset),
      .push        (rr_push),
      .push_packet (rr_push_packet),
      .full        (rr_full),
      .pop         (rxrr_rd),
      .valid       (rxrr_valid),
      .head_packet (rxrr_packet)
   );

endmodule

// ==== verif/erx_core_tb.sv ====
module erx_core_tb;

   // ########################################################################
   // Setup
   // ########################################################################

   // Per-wait limit in clock cycles
   localparam int timeout_cycles = 1000;
   // Three words per vector line
   localparam int vec_words = 192;

   logic                   clk;
   logic                   reset;
   logic                   erx_access;
   logic [erx_pkg::pw-1:0] erx_packet;
   logic                   erx_wait;
   logic                   edma_access;
   logic [erx_pkg::pw-1:0] edma_packet;
   logic                   edma_wait;
   logic                   ecfg_access;
   logic [erx_pkg::pw-1:0] ecfg_packet;
   logic                   ecfg_wait;
   logic                   rxwr_rd;
   logic                   rxwr_valid;
   logic [erx_pkg::pw-1:0] rxwr_packet;
   logic                   rxrd_rd;
   logic                   rxrd_valid;
   logic [erx_pkg::pw-1:0] rxrd_packet;
   logic                   rxrr_rd;
   logic                   rxrr_valid;
   logic [erx_pkg::pw-1:0] rxrr_packet;

   // Raw words from the vector file
   logic [erx_pkg::pw-1:0] vec_mem [vec_words];
   // Packets still to send, per source (0 erx, 1 edma, 2 ecfg)
   logic [erx_pkg::pw-1:0] pend_pkt [3][$];
   int                     pend_dst [3][$];
   // Scoreboard, index dst * 3 + src
   logic [erx_pkg::pw-1:0] expect_q [9][$];
   // Random popping allowed, per queue
   logic                   pop_en [3];
   string                  queue_name [3] = '{"rxwr", "rxrd", "rxrr"};

   erx_core dut (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // ########################################################################
   // Checks
   // ########################################################################

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_packet(input logic [erx_pkg::pw-1:0] got,
                               input logic [erx_pkg::pw-1:0] exp, input string what);
      if (got !== exp) begin
         report_failure($sformatf("ERROR at time %0t: %s got %h expected %h",
                                  $time, what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         report_failure($sformatf("ERROR at time %0t: %s got %b expected %b",
                                  $time, what, got, exp));
      end
   endtask

   // ########################################################################
   // Port lookup by index
   // ########################################################################

   function automatic logic wait_of(input int src);
      case (src)
         0: return erx_wait;
         1: return edma_wait;
         default: return ecfg_wait;
      endcase
   endfunction

   function automatic logic valid_of(input int q);
      case (q)
         0: return rxwr_valid;
         1: return rxrd_valid;
         default: return rxrr_valid;
      endcase
   endfunction

   function automatic logic rd_of(input int q);
      case (q)
         0: return rxwr_rd;
         1: return rxrd_rd;
         default: return rxrr_rd;
      endcase
   endfunction

   function automatic logic [erx_pkg::pw-1:0] packet_of(input int q);
      case (q)
         0: return rxwr_packet;
         1: return rxrd_packet;
         default: return rxrr_packet;
      endcase
   endfunction

   function automatic bit all_empty();
      for (int i = 0; i < 9; i++) begin
         if (expect_q[i].size() != 0) return 1'b0;
      end
      return 1'b1;
   endfunction

   // ########################################################################
   // Source drivers
   // ########################################################################

   task automatic drive_source(input int src, input logic acc,
                               input logic [erx_pkg::pw-1:0] pkt);
      case (src)
         0: begin
            erx_access = acc;
            erx_packet = pkt;
         end
         1: begin
            edma_access = acc;
            edma_packet = pkt;
         end
         default: begin
            ecfg_access = acc;
            ecfg_packet = pkt;
         end
      endcase
   endtask

   // Access held until a cycle with wait low
   task automatic send_all(input int src);
      logic [erx_pkg::pw-1:0] pkt;
      int                     dst;
      int                     cycles;
      logic                   taken;
      while (pend_pkt[src].size() != 0) begin
         pkt = pend_pkt[src].pop_front();
         dst = pend_dst[src].pop_front();
         drive_source(src, 1'b1, pkt);
         taken = 1'b0;
         cycles = 0;
         while (!taken) begin
            @(negedge clk);
            taken = !wait_of(src);
            @(posedge clk);
            cycles++;
            if (taken) begin
               expect_q[dst * 3 + src].push_back(pkt);
            end
            else if (cycles > timeout_cycles) begin
               report_failure($sformatf("Source %0d stayed in wait too long at %0t",
                                        src, $time));
            end
         end
         #1;
      end
      drive_source(src, 1'b0, '0);
   endtask

   // ########################################################################
   // Consumer side
   // ########################################################################

   // Head must match one source feeding this queue
   task automatic check_pop(input int q);
      logic [erx_pkg::pw-1:0] got;
      logic [erx_pkg::pw-1:0] exp;
      int                     hit;
      int                     pending;
      got = packet_of(q);
      exp = '0;
      hit = -1;
      pending = 0;
      for (int s = 2; s >= 0; s--) begin
         if (expect_q[q * 3 + s].size() != 0) begin
            pending++;
            exp = expect_q[q * 3 + s][0];
            if (exp === got) hit = s;
         end
      end
      if (pending == 0) begin
         report_failure($sformatf("Queue %s popped at %0t with nothing expected",
                                  queue_name[q], $time));
      end
      else if (hit < 0) begin
         // No source head matches this packet
         check_packet(got, exp, {queue_name[q], " head"});
      end
      else begin
         void'(expect_q[q * 3 + hit].pop_front());
      end
   endtask

   // Pop decided at mid cycle, takes effect on the next edge
   always @(negedge clk) begin
      if (!reset) begin
         for (int q = 0; q < 3; q++) begin
            if (rd_of(q) && valid_of(q)) check_pop(q);
         end
      end
   end

   // Random pop strobes, about three cycles in four
   always @(posedge clk) begin
      #1;
      rxwr_rd = pop_en[0] && ($urandom_range(3) != 0);
      rxrd_rd = pop_en[1] && ($urandom_range(3) != 0);
      rxrr_rd = pop_en[2] && ($urandom_range(3) != 0);
   end

   // ########################################################################
   // Groups
   // ########################################################################

   task automatic drain_all();
      int cycles;
      cycles = 0;
      while (!all_empty()) begin
         @(negedge clk);
         cycles++;
         if (cycles > timeout_cycles) begin
            report_failure($sformatf("Queues did not drain by %0t", $time));
         end
      end
      // Last pop lands on the coming edge
      @(negedge clk);
      for (int q = 0; q < 3; q++) begin
         check_flag(valid_of(q), 1'b0, {queue_name[q], " valid after drain"});
         check_flag(wait_of(q), 1'b0, $sformatf("source %0d wait after drain", q));
      end
   endtask

   // Queue held full must push back on its source
   task automatic expect_wait(input int src, input int q);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!wait_of(src)) begin
         @(negedge clk);
         cycles++;
         if (cycles > timeout_cycles) begin
            report_failure($sformatf("Source %0d wait never rose with %s full",
                                     src, queue_name[q]));
         end
      end
      check_flag(valid_of(q), 1'b1, {queue_name[q], " valid while held"});
   endtask

   task automatic run_group(input int hold_q, input int wait_src);
      if (hold_q >= 0) begin
         @(negedge clk);
         pop_en[hold_q] = 1'b0;
      end
      @(posedge clk);
      #1;
      fork
         send_all(0);
         send_all(1);
         send_all(2);
      join
      if (hold_q >= 0) begin
         expect_wait(wait_src, hold_q);
         pop_en[hold_q] = 1'b1;
      end
      drain_all();
   endtask

   // ########################################################################
   // Main sequence
   // ########################################################################

   initial begin
      int                     idx;
      bit                     done;
      logic [3:0]             src_code;
      logic [erx_pkg::pw-1:0] pkt_word;
      logic [erx_pkg::pw-1:0] q_word;
      void'($urandom(32'hcf1d));
      reset = 1'b1;
      drive_source(0, 1'b0, '0);
      drive_source(1, 1'b0, '0);
      drive_source(2, 1'b0, '0);
      rxwr_rd = 1'b0;
      rxrd_rd = 1'b0;
      rxrr_rd = 1'b0;
      for (int q = 0; q < 3; q++) pop_en[q] = 1'b0;
      $readmemh("verif/erx_vectors.txt", vec_mem);
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      // Quiet outputs out of reset
      for (int q = 0; q < 3; q++) begin
         check_flag(valid_of(q), 1'b0, {queue_name[q], " valid after reset"});
         check_flag(wait_of(q), 1'b0, $sformatf("source %0d wait after reset", q));
         pop_en[q] = 1'b1;
      end
      idx = 0;
      done = 1'b0;
      while (!done) begin
         if (idx + 3 > vec_words) begin
            report_failure("Vector file has no end marker");
         end
         src_code = vec_mem[idx][3:0];
         pkt_word = vec_mem[idx + 1];
         q_word = vec_mem[idx + 2];
         idx += 3;
         if (src_code == 4'hf) begin
            // Control word, command in [7:4], watched source in [3:0]
            if (pkt_word[7:4] == 4'hf) done = 1'b1;
            else if (pkt_word[7:4] == 4'h1) run_group(int'(q_word[1:0]), int'(pkt_word[3:0]));
            else run_group(-1, 0);
         end
         else if (src_code <= 4'd2) begin
            pend_pkt[int'(src_code)].push_back(pkt_word);
            pend_dst[int'(src_code)].push_back(int'(q_word[1:0]));
         end
         else begin
            report_failure($sformatf("Unknown source code %h in vector file", src_code));
         end
      end
      // Every listed packet went out in some group
      for (int s = 0; s < 3; s++) begin
         if (pend_pkt[s].size() != 0) begin
            report_failure($sformatf("Source %0d still had packets unsent at the end", s));
         end
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== verif/erx_vectors.txt ====
// Columns: source (0 erx, 1 edma, 2 ecfg, f control), packet (104-bit hex), queue (0 rxwr, 1 rxrd, 2 rxrr)
// Control packet word: [7:4] command (0 run and drain, 1 hold queue popping, f end), [3:0] source whose wait must rise

// Link writes and reads away from our ID
0 a0000000d00000012000001005 0
0 a0000000d00000022000001404 1
0 a0000000d00000033000002005 0
0 a0000000d00000043000002404 1
0 a0000000d00000057ff0000005 0
0 a0000000d0000006801ff00004 1
f 00 0

// Link traffic for ID 800 mixed with register readback
0 a0000000d00000118000010005 2
2 c0000000d00000218000000c04 2
0 a0000000d00000128000010404 2
2 c0000000d00000228000001004 2
0 a0000000d0000013800ff00005 2
2 c0000000d00000238000001404 2
0 a0000000d0000014800fff0004 2
2 c0000000d00000248000001804 2
f 00 0

// DMA reads interleaved with link reads
1 b0000000d00000314000000004 1
0 a0000000d00000324000010004 1
1 b0000000d00000334000000404 1
0 a0000000d00000344000010404 1
1 b0000000d00000354000000804 1
0 a0000000d00000364000010804 1
1 b0000000d00000374000000c04 1
f 00 0

// Write queue held full, ninth write stays in the ingress register
0 a0000000d00000415000000005 0
0 a0000000d00000425000000405 0
0 a0000000d00000435000000805 0
0 a0000000d00000445000000c05 0
0 a0000000d00000455000001005 0
0 a0000000d00000465000001405 0
0 a0000000d00000475000001805 0
0 a0000000d00000485000001c05 0
0 a0000000d00000495000002005 0
f 10 0

f f0 0

// ==== erx_core.f ====
verilog/erx_pkg.sv
verilog/erx_ingress.sv
verilog/erx_arbiter.sv
verilog/erx_fifo.sv
verilog/erx_core.sv
verif/erx_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := erx_core_tb
FILELIST  := erx_core.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_TEXT := Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
